//--- filelist.f
verilog/exu_csr_pkg.sv
verilog/csr_op_unit.sv
verilog/trap_unit.sv
verilog/exu_csr.sv
verilog/exu_csr_top.sv
test/tb_exu_csr.sv

//--- Makefile
# Verilator build and run of the CSR execute slice testbench.

SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_exu_csr: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_exu_csr -f filelist.f

run: obj_dir/Vtb_exu_csr
	./obj_dir/Vtb_exu_csr > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "Done: errors found" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi; \
	if ! grep -q "Done: no errors" sim.log; then \
	  echo "simulation ended without a result"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf obj_dir sim.log

//--- test/tb_exu_csr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_csr
  import exu_csr_pkg::*;
();

  localparam int clk_period = 40;
  localparam int num_tests  = 6;
  localparam int rand_ops   = 200;

  logic      clk;
  logic      rst;
  logic      valid;
  exu_op_t   op;
  csr_addr_t csr_addr;
  xword_t    src;
  xword_t    pc;
  xword_t    rdata;
  logic      redirect;
  xword_t    redirect_pc;

  // model slots in the order mstatus, mtvec, mepc, mcause.
  xword_t      model [4];
  logic [31:0] seed;
  int          errors;
  int          checks;

  exu_csr_top #(
    .RESET_VAL (32'h0)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .valid       (valid),
    .op          (op),
    .csr_addr    (csr_addr),
    .src         (src),
    .pc          (pc),
    .rdata       (rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic int slot_of(input csr_addr_t a);
    case (a)
      csr_mstatus: return 0;
      csr_mtvec:   return 1;
      csr_mepc:    return 2;
      csr_mcause:  return 3;
      default:     return -1;
    endcase
  endfunction

  function automatic csr_addr_t addr_of_slot(input int s);
    case (s)
      0:       return csr_mstatus;
      1:       return csr_mtvec;
      2:       return csr_mepc;
      default: return csr_mcause;
    endcase
  endfunction

  function automatic xword_t expect_read(input csr_addr_t a);
    int s;
    s = slot_of(a);
    if (s >= 0) return model[s];
    if (a == csr_mvendorid) return mvendorid_val;
    if (a == csr_marchid) return marchid_val;
    return '0;
  endfunction

  function automatic exu_op_t pick_op(input logic [31:0] r);
    case (r % 32'd6)
      0:       return op_none;
      1:       return op_csrrw;
      2:       return op_csrrs;
      3:       return op_csrrc;
      4:       return op_ecall;
      default: return op_mret;
    endcase
  endfunction

  // includes the identity words and one unmapped address.
  function automatic csr_addr_t pick_addr(input logic [31:0] r);
    case (r % 32'd7)
      0:       return csr_mstatus;
      1:       return csr_mtvec;
      2:       return csr_mepc;
      3:       return csr_mcause;
      4:       return csr_mvendorid;
      5:       return csr_marchid;
      default: return 12'h7c0;
    endcase
  endfunction

  task automatic check_value(input string what, input xword_t got, input xword_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one cycle of the stage checked against the model.
  task automatic exec_op(input logic v, input exu_op_t o, input csr_addr_t a,
                         input xword_t s, input xword_t p);
    xword_t upd [4];
    xword_t old;
    int     slot;
    logic   exp_redirect;
    xword_t exp_target;
    @(negedge clk);
    valid    = v;
    op       = o;
    csr_addr = a;
    src      = s;
    pc       = p;
    old          = expect_read(a);
    slot         = slot_of(a);
    upd          = model;
    exp_redirect = 1'b0;
    exp_target   = '0;
    case (o)
      op_csrrw: if (slot >= 0) upd[slot] = s;
      op_csrrs: if (slot >= 0) upd[slot] = old | s;
      op_csrrc: if (slot >= 0) upd[slot] = old & ~s;
      op_ecall: begin
        upd[2] = p;
        upd[3] = cause_ecall_m;
        upd[0][mstatus_mpie_idx] = model[0][mstatus_mie_idx];
        upd[0][mstatus_mie_idx]  = 1'b0;
        exp_redirect = 1'b1;
        exp_target   = {model[1][xlen-1:2], 2'b00};
      end
      op_mret: begin
        upd[0][mstatus_mie_idx]  = model[0][mstatus_mpie_idx];
        upd[0][mstatus_mpie_idx] = 1'b1;
        exp_redirect = 1'b1;
        exp_target   = model[2];
      end
      default: ;
    endcase
    #(clk_period / 4);
    check_value("rdata", rdata, old);
    check_value("redirect", {31'b0, redirect}, {31'b0, exp_redirect});
    if (exp_redirect) check_value("redirect_pc", redirect_pc, exp_target);
    @(posedge clk);
    if (v) model = upd;
  endtask

  task automatic read_check(input csr_addr_t a, input xword_t exp);
    @(negedge clk);
    valid    = 1'b0;
    op       = op_none;
    csr_addr = a;
    src      = '0;
    pc       = '0;
    #(clk_period / 4);
    check_value($sformatf("csr %h", a), rdata, exp);
  endtask

  task automatic verify_model();
    for (int i = 0; i < 4; i++) read_check(addr_of_slot(i), model[i]);
  endtask

  task automatic reset_state_reads();
    read_check(csr_mstatus, 32'h0);
    read_check(csr_mtvec, 32'h0);
    read_check(csr_mepc, 32'h0);
    read_check(csr_mcause, 32'h0);
    read_check(csr_mvendorid, mvendorid_val);
    read_check(csr_marchid, marchid_val);
    read_check(12'h7c0, 32'h0);
  endtask

  task automatic csr_rmw_ops();
    exu_op_t ops [3];
    ops = '{op_csrrw, op_csrrs, op_csrrc};
    foreach (ops[i]) begin
      for (int j = 0; j < 4; j++) begin
        exec_op(1'b1, ops[i], addr_of_slot(j), rand_word(), 32'h0);
        read_check(addr_of_slot(j), expect_read(addr_of_slot(j)));
      end
    end
    // identity registers ignore writes.
    exec_op(1'b1, op_csrrw, csr_mvendorid, rand_word(), 32'h0);
    read_check(csr_mvendorid, mvendorid_val);
    verify_model();
  endtask

  task automatic valid_low_holds();
    xword_t  snap [4];
    exu_op_t ops [5];
    snap = model;
    ops  = '{op_csrrw, op_csrrs, op_csrrc, op_ecall, op_mret};
    foreach (ops[i]) begin
      exec_op(1'b0, ops[i], addr_of_slot(i % 4), rand_word(), rand_word());
    end
    for (int i = 0; i < 4; i++) read_check(addr_of_slot(i), snap[i]);
  endtask

  task automatic ecall_entry();
    xword_t epc;
    epc = rand_word();
    exec_op(1'b1, op_csrrw, csr_mtvec, rand_word(), 32'h0);
    exec_op(1'b1, op_csrrw, csr_mstatus, 32'h0000_0008, 32'h0);
    exec_op(1'b1, op_ecall, 12'h000, 32'h0, epc);
    read_check(csr_mepc, epc);
    read_check(csr_mcause, 32'd11);
    read_check(csr_mstatus, 32'h0000_0080);
  endtask

  task automatic mret_exit();
    exec_op(1'b1, op_mret, 12'h000, 32'h0, 32'h0);
    read_check(csr_mstatus, 32'h0000_0088);
  endtask

  task automatic random_sequence();
    logic [31:0] r;
    repeat (rand_ops) begin
      r = rand_word();
      exec_op(r[31:28] != 4'h0, pick_op(r), pick_addr(r >> 8), rand_word(), rand_word());
    end
    verify_model();
  endtask

  initial begin
    seed     = 32'h40b8_057d;
    errors   = 0;
    checks   = 0;
    rst      = 1'b1;
    valid    = 1'b0;
    op       = op_none;
    csr_addr = '0;
    src      = '0;
    pc       = '0;
    for (int i = 0; i < 4; i++) model[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reset_state_reads();
    csr_rmw_ops();
    valid_low_holds();
    ecall_entry();
    mret_exit();
    random_sequence();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // budget of 40 cycles per test plus two per random operation.
  initial begin
    #((num_tests * 40 + 2 * rand_ops) * clk_period);
    $display("timeout: the tests did not finish within %0d cycles",
             num_tests * 40 + 2 * rand_ops);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/exu_csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_csr_top
  import exu_csr_pkg::*;
#(
  parameter xword_t RESET_VAL = '0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid,
  input  exu_op_t   op,
  input  csr_addr_t csr_addr,
  input  xword_t    src,
  input  xword_t    pc,
  output xword_t    rdata,
  output logic      redirect,
  output xword_t    redirect_pc
);

  csr_wr_t      op_wr;
  csr_wr_t      trap_wr_a;
  csr_wr_t      trap_wr_b;
  mstatus_act_t act;
  xword_t       mtvec;
  xword_t       mepc;

  // read-modify-write for csrrw, csrrs and csrrc.
  csr_op_unit u_csr_op_unit (
    .csr_addr (csr_addr),
    .op       (op),
    .src      (src),
    .old      (rdata),
    .wr       (op_wr)
  );

  // ecall and mret.
  trap_unit u_trap_unit (
    .op          (op),
    .pc          (pc),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .wr_a        (trap_wr_a),
    .wr_b        (trap_wr_b),
    .act         (act),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  exu_csr #(
    .RESET_VAL (RESET_VAL)
  ) u_exu_csr (
    .clk   (clk),
    .rst   (rst),
    .valid (valid),
    .raddr (csr_addr),
    .wr_op (op_wr),
    .wr_a  (trap_wr_a),
    .wr_b  (trap_wr_b),
    .act   (act),
    .rdata (rdata),
    .mtvec (mtvec),
    .mepc  (mepc)
  );

endmodule

`default_nettype wire

//--- verilog/exu_csr.sv
`timescale 1ns/1ps
`default_nettype none

module exu_csr
  import exu_csr_pkg::*;
#(
  parameter xword_t RESET_VAL = '0
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         valid,
  input  csr_addr_t    raddr,
  input  csr_wr_t      wr_op,
  input  csr_wr_t      wr_a,
  input  csr_wr_t      wr_b,
  input  mstatus_act_t act,
  output xword_t       rdata,
  output xword_t       mtvec,
  output xword_t       mepc
);

  xword_t mstatus_q;
  xword_t mtvec_q;
  xword_t mepc_q;
  xword_t mcause_q;

  xword_t mstatus_wr;
  xword_t mstatus_d;
  xword_t mtvec_d;
  xword_t mepc_d;
  xword_t mcause_d;

  // later ports win, so trap writes override the csr op.
  function automatic xword_t merge(input xword_t cur, input csr_idx_t slot,
                                   input csr_wr_t p0, input csr_wr_t p1,
                                   input csr_wr_t p2);
    xword_t val;
    val = cur;
    if (p0.en && p0.idx == slot) val = p0.data;
    if (p1.en && p1.idx == slot) val = p1.data;
    if (p2.en && p2.idx == slot) val = p2.data;
    return val;
  endfunction

  always_comb begin
    mtvec_d    = merge(mtvec_q, idx_mtvec, wr_op, wr_a, wr_b);
    mepc_d     = merge(mepc_q, idx_mepc, wr_op, wr_a, wr_b);
    mcause_d   = merge(mcause_q, idx_mcause, wr_op, wr_a, wr_b);
    mstatus_wr = merge(mstatus_q, idx_mstatus, wr_op, wr_a, wr_b);

    // interrupt enable stack, based on the current mstatus.
    mstatus_d = mstatus_wr;
    case (act)
      act_trap: begin
        mstatus_d[mstatus_mpie_idx] = mstatus_q[mstatus_mie_idx];
        mstatus_d[mstatus_mie_idx]  = 1'b0;
      end
      act_ret: begin
        mstatus_d[mstatus_mie_idx]  = mstatus_q[mstatus_mpie_idx];
        mstatus_d[mstatus_mpie_idx] = 1'b1;
      end
      default: begin
        mstatus_d = mstatus_wr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= RESET_VAL;
      mtvec_q   <= RESET_VAL;
      mepc_q    <= RESET_VAL;
      mcause_q  <= RESET_VAL;
    end else if (valid) begin
      mstatus_q <= mstatus_d;
      mtvec_q   <= mtvec_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  // one-hot and-or read, unknown addresses give zero.
  assign rdata = ({xlen{raddr == csr_mvendorid}} & mvendorid_val) |
                 ({xlen{raddr == csr_marchid}}   & marchid_val)   |
                 ({xlen{raddr == csr_mstatus}}   & mstatus_q)     |
                 ({xlen{raddr == csr_mtvec}}     & mtvec_q)       |
                 ({xlen{raddr == csr_mepc}}      & mepc_q)        |
                 ({xlen{raddr == csr_mcause}}    & mcause_q);

  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

endmodule

`default_nettype wire

//--- verilog/trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module trap_unit
  import exu_csr_pkg::*;
(
  input  exu_op_t      op,
  input  xword_t       pc,
  input  xword_t       mtvec,
  input  xword_t       mepc,
  output csr_wr_t      wr_a,
  output csr_wr_t      wr_b,
  output mstatus_act_t act,
  output logic         redirect,
  output xword_t       redirect_pc
);

  xword_t trap_base;

  // direct mode only, mode bits ignored.
  assign trap_base = {mtvec[xlen-1:2], 2'b00};

  always_comb begin
    wr_a.en     = 1'b0;
    wr_a.idx    = idx_none;
    wr_a.data   = '0;
    wr_b.en     = 1'b0;
    wr_b.idx    = idx_none;
    wr_b.data   = '0;
    act         = act_none;
    redirect    = 1'b0;
    redirect_pc = '0;

    case (op)
      op_ecall: begin
        // save the faulting pc and the cause.
        wr_a.en     = 1'b1;
        wr_a.idx    = idx_mepc;
        wr_a.data   = pc;
        wr_b.en     = 1'b1;
        wr_b.idx    = idx_mcause;
        wr_b.data   = cause_ecall_m;
        act         = act_trap;
        redirect    = 1'b1;
        redirect_pc = trap_base;
      end
      op_mret: begin
        act         = act_ret;
        redirect    = 1'b1;
        redirect_pc = mepc;
      end
      default: begin
        act = act_none;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/csr_op_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit
  import exu_csr_pkg::*;
(
  input  csr_addr_t csr_addr,
  input  exu_op_t   op,
  input  xword_t    src,
  input  xword_t    old,
  output csr_wr_t   wr
);

  csr_idx_t idx;
  xword_t   new_val;
  logic     is_csr_op;

  // read-only and unknown addresses fall into the none slot.
  always_comb begin
    case (csr_addr)
      csr_mstatus: idx = idx_mstatus;
      csr_mtvec:   idx = idx_mtvec;
      csr_mepc:    idx = idx_mepc;
      csr_mcause:  idx = idx_mcause;
      default:     idx = idx_none;
    endcase
  end

  always_comb begin
    is_csr_op = 1'b1;
    case (op)
      op_csrrw: new_val = src;
      op_csrrs: new_val = old | src;
      op_csrrc: new_val = old & ~src;
      default: begin
        new_val   = old;
        is_csr_op = 1'b0;
      end
    endcase
  end

  always_comb begin
    wr.en   = is_csr_op;
    wr.idx  = idx;
    wr.data = new_val;
  end

endmodule

`default_nettype wire

//--- verilog/exu_csr_pkg.sv
`default_nettype none

package exu_csr_pkg;

  localparam int xlen = 32;

  typedef logic [11:0]     csr_addr_t;
  typedef logic [xlen-1:0] xword_t;

  // standard machine-mode addresses.
  localparam csr_addr_t csr_mstatus   = 12'h300;
  localparam csr_addr_t csr_mtvec     = 12'h305;
  localparam csr_addr_t csr_mepc      = 12'h341;
  localparam csr_addr_t csr_mcause    = 12'h342;
  localparam csr_addr_t csr_mvendorid = 12'hf11;
  localparam csr_addr_t csr_marchid   = 12'hf12;

  localparam int mstatus_mie_idx  = 3;
  localparam int mstatus_mpie_idx = 7;

  // identity words, read only.
  localparam xword_t mvendorid_val = 32'h5253_4356;
  localparam xword_t marchid_val   = 32'h0000_0019;

  localparam xword_t cause_ecall_m = 32'd11;

  // internal storage slots, none is a discard slot.
  typedef enum logic [2:0] {
    idx_none    = 3'd0,
    idx_mcause  = 3'd1,
    idx_mepc    = 3'd2,
    idx_mtvec   = 3'd3,
    idx_mstatus = 3'd4
  } csr_idx_t;

  typedef enum logic [2:0] {
    op_none,
    op_csrrw,
    op_csrrs,
    op_csrrc,
    op_ecall,
    op_mret
  } exu_op_t;

  typedef enum logic [1:0] {
    act_none,
    act_trap,
    act_ret
  } mstatus_act_t;

  typedef struct packed {
    logic     en;
    csr_idx_t idx;
    xword_t   data;
  } csr_wr_t;

endpackage

`default_nettype wire
